//--- tb.f
+incdir+logic
logic/rvTypes_pkg.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/immExtend.sv
logic/alu.sv
logic/regFile.sv
logic/pcSelect.sv
logic/execStage.sv
sim/execStage_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvTypes_pkg.sv
      - logic/mainDecoder.sv
      - logic/aluDecoder.sv
      - logic/immExtend.sv
      - logic/alu.sv
      - logic/regFile.sv
      - logic/pcSelect.sv
      - logic/execStage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/execStage_tb.sv

//--- sim/execStage_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module execStage_tb;

    import rvTypes_pkg::*;

    localparam int MAX_ENTRIES  = 64;
    localparam int NUM_RANDOM   = 40;
    localparam int RESET_CYCLES = 5;

    logic             clk;
    logic             rstN;
    instrT            instr;
    logic [`XLEN-1:0] pc;
    logic             instrValid;
    logic [`XLEN-1:0] readData;
    logic [`XLEN-1:0] memAddr;
    logic [`XLEN-1:0] memWriteData;
    logic             memWrite;
    logic [`XLEN-1:0] pcNext;

    // Stimulus table applied one entry per cycle
    logic [31:0]      tInstr  [MAX_ENTRIES];
    logic [31:0]      tPc     [MAX_ENTRIES];
    logic [31:0]      tRdata  [MAX_ENTRIES];
    logic             tValid  [MAX_ENTRIES];
    logic [31:0]      tPcNext [MAX_ENTRIES];
    logic             tMemWr  [MAX_ENTRIES];
    logic [31:0]      tAddr   [MAX_ENTRIES];
    logic [31:0]      tData   [MAX_ENTRIES];
    int               numEntries;
    int               cycleCount;
    int               timeoutLimit;
    int               seed;
    logic [`XLEN-1:0] modelRegs [`REG_COUNT];   // Expected register contents

    execStage dut_i (
        .clk          (clk),
        .rstN         (rstN),
        .instr        (instr),
        .pc           (pc),
        .instrValid   (instrValid),
        .readData     (readData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .pcNext       (pcNext)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("Errors found");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value check failed");
        end
    endtask

    // Instruction encoders in base format field order
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    // ISA result of an OP or OP-IMM function
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic isSub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // x0 or x18..x31 which the table never writes
    function automatic logic [4:0] pickReg();
        int r;
        r = $unsigned($random(seed)) % 15;
        return (r == 0) ? 5'd0 : 5'(17 + r);
    endfunction

    task automatic addEntry(input logic [31:0] ins, input logic [31:0] pcIn,
                            input logic [31:0] rdat, input logic valid,
                            input logic [31:0] expPc, input logic expWr,
                            input logic [31:0] expAddr, input logic [31:0] expData);
        tInstr[numEntries]  = ins;
        tPc[numEntries]     = pcIn;
        tRdata[numEntries]  = rdat;
        tValid[numEntries]  = valid;
        tPcNext[numEntries] = expPc;
        tMemWr[numEntries]  = expWr;
        tAddr[numEntries]   = expAddr;
        tData[numEntries]   = expData;
        numEntries++;
    endtask

    task automatic addOp(input logic [31:0] ins);
        addEntry(ins, 32'h100, 32'h0, 1'b1, 32'h104, 1'b0, 32'h0, 32'h0);
    endtask

    task automatic addStore(input logic [4:0] rs2, input logic [31:0] expData);
        addEntry(encS(12'h000, rs2, 5'd0), 32'h100, 32'h0, 1'b1, 32'h104, 1'b1, 32'h0, expData);
    endtask

    task automatic buildTable();
        addEntry(encS(12'h008, 5'd5, 5'd0), 32'h100, 32'h0, 1'b1, 32'h104, 1'b1, 32'h8, 32'h0);
        addOp(encI(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));         // addi x0 ignored
        addStore(5'd0, 32'h0);
        addOp(encI(12'd100, 5'd0, 3'b000, 5'd1, OP_IMM));         // x1 = 100
        addOp(encI(12'hFF9, 5'd0, 3'b000, 5'd2, OP_IMM));         // x2 = -7
        addEntry(encS(12'hFFC, 5'd2, 5'd1), 32'h100, 32'h0, 1'b1, 32'h104, 1'b1,
                 32'h60, 32'hFFFF_FFF9);                          // Negative S offset
        addOp(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        addStore(5'd3, 32'h5D);
        addOp(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        addStore(5'd4, 32'h6B);
        addOp(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        addStore(5'd5, 32'h60);
        addOp(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        addStore(5'd6, 32'hFFFF_FFFD);
        addOp(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        addStore(5'd7, 32'hFFFF_FF9D);
        addOp(encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));             // -7 < 100
        addStore(5'd8, 32'h1);
        addOp(encI(12'd4, 5'd0, 3'b000, 5'd10, OP_IMM));
        addOp(encR(7'h00, 5'd10, 5'd1, 3'b001, 5'd11));
        addStore(5'd11, 32'h640);
        addOp(encR(7'h00, 5'd10, 5'd2, 3'b101, 5'd12));           // Logical shift fills zeros
        addStore(5'd12, 32'h0FFF_FFFF);
        addEntry(encI(12'h004, 5'd1, 3'b010, 5'd13, OP_LOAD), 32'h100, 32'hCAFE_F00D, 1'b1,
                 32'h104, 1'b0, 32'h68, 32'h0);                   // Address is x1 + 4
        addStore(5'd13, 32'hCAFE_F00D);
        addOp(encU(20'hABCDE, 5'd14));
        addStore(5'd14, 32'hABCD_E000);
        addEntry(encB(13'h0010, 5'd1, 5'd1, 3'b000), 32'h200, 32'h0, 1'b1, 32'h210, 1'b0, 0, 0);
        addEntry(encB(13'h0010, 5'd2, 5'd1, 3'b000), 32'h200, 32'h0, 1'b1, 32'h204, 1'b0, 0, 0);
        addEntry(encB(13'h1FF8, 5'd2, 5'd1, 3'b001), 32'h200, 32'h0, 1'b1, 32'h1F8, 1'b0, 0, 0);
        addEntry(encB(13'h1FF8, 5'd1, 5'd1, 3'b001), 32'h200, 32'h0, 1'b1, 32'h204, 1'b0, 0, 0);
        addEntry(encJ(21'h00800, 5'd15), 32'h300, 32'h0, 1'b1, 32'hB00, 1'b0, 0, 0);
        addStore(5'd15, 32'h304);                                 // jal link
        addEntry(encI(12'h007, 5'd1, 3'b000, 5'd16, OP_JALR), 32'h400, 32'h0, 1'b1,
                 32'h6A, 1'b0, 32'h0, 32'h0);                     // 107 with bit 0 cleared
        addStore(5'd16, 32'h404);
        addEntry(encI(12'd55, 5'd0, 3'b000, 5'd17, OP_IMM), 32'h100, 32'h0, 1'b0,
                 32'h104, 1'b0, 32'h0, 32'h0);                    // Dropped while not valid
        addEntry(encS(12'h000, 5'd17, 5'd0), 32'h100, 32'h0, 1'b0, 32'h104, 1'b0, 32'h0, 32'h0);
        addStore(5'd17, 32'h0);
    endtask

    task automatic runRandom();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        isR;
        logic        isSub;
        logic [11:0] imm;
        logic [31:0] expVal;
        repeat (NUM_RANDOM) begin
            isR   = $random(seed);
            f3    = $random(seed);
            imm   = $random(seed);
            isSub = $random(seed);
            rs1   = pickReg();
            rs2   = pickReg();
            rd    = pickReg();
            if (f3 == 3'b011) begin
                f3 = 3'b010;                                      // No sltu
            end
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm[11:5] = 7'h00;                                // Plain shift amount
            end
            isSub  = isSub && isR && (f3 == 3'b000);
            expVal = aluModel(f3, isSub, modelRegs[rs1],
                              isR ? modelRegs[rs2] : {{20{imm[11]}}, imm});
            @(negedge clk);
            instr      = isR ? encR(isSub ? 7'h20 : 7'h00, rs2, rs1, f3, rd)
                             : encI(imm, rs1, f3, rd, OP_IMM);
            pc         = 32'h800;
            instrValid = 1'b1;
            #2;
            checkEq(pcNext, 32'h800 + `PC_STEP, "random op pcNext");
            checkEq(memWrite, 1'b0, "random op memWrite");
            if (rd != 5'd0) begin
                modelRegs[rd] = expVal;
            end
            @(negedge clk);
            instr = encS(12'h000, rd, 5'd0);                      // Read rd back through sw
            #2;
            checkEq(memWrite, 1'b1, "random readback memWrite");
            checkEq(memWriteData, modelRegs[rd], $sformatf("random readback x%0d", rd));
        end
    endtask

    initial begin
        seed       = 59477;
        cycleCount = 0;
        numEntries = 0;
        buildTable();
        timeoutLimit = RESET_CYCLES + numEntries + 2 * NUM_RANDOM + 20;
        rstN       = 1'b0;
        instr      = '0;
        pc         = '0;
        instrValid = 1'b0;
        readData   = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < numEntries; i++) begin
            @(negedge clk);
            instr      = tInstr[i];
            pc         = tPc[i];
            readData   = tRdata[i];
            instrValid = tValid[i];
            #2;
            checkEq(pcNext, tPcNext[i], $sformatf("entry %0d pcNext", i));
            checkEq(memWrite, tMemWr[i], $sformatf("entry %0d memWrite", i));
            if (tInstr[i][6:0] == OP_STORE || tInstr[i][6:0] == OP_LOAD) begin
                checkEq(memAddr, tAddr[i], $sformatf("entry %0d memAddr", i));
            end
            if (tInstr[i][6:0] == OP_STORE) begin
                checkEq(memWriteData, tData[i], $sformatf("entry %0d memWriteData", i));
            end
        end
        readData = '0;
        runRandom();
        @(negedge clk);
        instrValid = 1'b0;
        $display("No errors");
        $finish;
    end

endmodule

//--- logic/execStage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module execStage (
    input  logic               clk,
    input  logic               rstN,
    input  rvTypes_pkg::instrT instr,
    input  logic [`XLEN-1:0]   pc,
    input  logic               instrValid,
    input  logic [`XLEN-1:0]   readData,      // Must arrive with memAddr
    output logic [`XLEN-1:0]   memAddr,
    output logic [`XLEN-1:0]   memWriteData,
    output logic               memWrite,
    output logic [`XLEN-1:0]   pcNext
);

    import rvTypes_pkg::*;

    branchT           branch;
    immSrcT           immSrc;
    resultSrcT        resultSrc;
    aluCtrlT          aluCtrl;
    logic             aluSrc;
    logic             regWrite;
    logic             memWriteDec;
    logic [1:0]       aluOp;
    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             zero;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] result;

    mainDecoder mainDec_i (
        .op        (opcodeT'(instr.r.opcode)),
        .branch    (branch),
        .immSrc    (immSrc),
        .aluSrc    (aluSrc),
        .resultSrc (resultSrc),
        .regWrite  (regWrite),
        .memWrite  (memWriteDec),
        .aluOp     (aluOp)
    );

    aluDecoder aluDec_i (
        .aluOp    (aluOp),
        .funct3   (instr.r.funct3),
        .funct7b5 (instr.r.funct7[5]),
        .opb5     (instr.r.opcode[5]),
        .aluCtrl  (aluCtrl)
    );

    immExtend immExt_i (
        .instr  (instr),
        .immSrc (immSrc),
        .immExt (immExt)
    );

    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .we   (instrValid & regWrite),   // No write without a valid instruction
        .ra1  (instr.r.rs1),
        .ra2  (instr.r.rs2),
        .wa   (instr.r.rd),
        .wd   (result),
        .rd1  (rs1Data),
        .rd2  (rs2Data)
    );

    assign srcB = aluSrc ? immExt : rs2Data;

    alu alu_i (
        .a       (rs1Data),
        .b       (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .zero    (zero)
    );

    pcSelect pcSel_i (
        .pc        (pc),
        .immExt    (immExt),
        .aluResult (aluResult),
        .branch    (branch),
        .funct3b0  (instr.r.funct3[0]),
        .zero      (zero),
        .pcNext    (pcNext),
        .pcPlus4   (pcPlus4)
    );

    // Write-back select
    always_comb begin
        case (resultSrc)
            RES_IMM: result = immExt;
            RES_PC4: result = pcPlus4;     // Link for jal and jalr
            RES_MEM: result = readData;
            default: result = aluResult;
        endcase
    end

    assign memAddr      = aluResult;
    assign memWriteData = rs2Data;
    assign memWrite     = instrValid & memWriteDec;

endmodule

//--- logic/pcSelect.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module pcSelect (
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    immExt,
    input  logic [`XLEN-1:0]    aluResult,
    input  rvTypes_pkg::branchT branch,
    input  logic                funct3b0,   // 0 for beq, 1 for bne
    input  logic                zero,
    output logic [`XLEN-1:0]    pcNext,
    output logic [`XLEN-1:0]    pcPlus4
);

    import rvTypes_pkg::*;

    logic [`XLEN-1:0] pcTarget;
    logic             condTaken;

    assign pcPlus4   = pc + `PC_STEP;
    assign pcTarget  = pc + immExt;
    assign condTaken = zero ^ funct3b0;

    always_comb begin
        case (branch)
            BR_COND: pcNext = condTaken ? pcTarget : pcPlus4;
            BR_JAL:  pcNext = pcTarget;
            BR_JALR: pcNext = {aluResult[`XLEN-1:1], 1'b0};   // Clear bit 0
            default: pcNext = pcPlus4;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`XLEN-1:0]       wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;                       // x0 is never written
        end
    end

    // Combinational reads, new data visible the cycle after a write
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
    input  logic [`XLEN-1:0]     a,
    input  logic [`XLEN-1:0]     b,
    input  rvTypes_pkg::aluCtrlT aluCtrl,
    output logic [`XLEN-1:0]     result,
    output logic                 zero
);

    import rvTypes_pkg::*;

    logic       lessThan;
    logic [4:0] shamt;

    assign lessThan = $signed(a) < $signed(b);   // Signed compare for slt
    assign shamt    = b[4:0];

    always_comb begin
        case (aluCtrl)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`XLEN-1){1'b0}}, lessThan};
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;       // Logical, no sign fill
            default: result = '0;
        endcase
    end

    // Branch compare uses this after a subtract
    assign zero = (result == '0);

endmodule

//--- logic/immExtend.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module immExtend (
    input  rvTypes_pkg::instrT  instr,
    input  rvTypes_pkg::immSrcT immSrc,
    output logic [`XLEN-1:0]    immExt
);

    import rvTypes_pkg::*;

    always_comb begin
        case (immSrc)
            IMM_I: begin
                immExt = {{(`XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
            end
            IMM_S: begin
                immExt = {{(`XLEN-12){instr.s.imm11_5[6]}},
                          instr.s.imm11_5, instr.s.imm4_0};
            end
            IMM_B: begin
                // Halfword offset, bit 0 implied zero
                immExt = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            IMM_J: begin
                immExt = {{(`XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                          instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            IMM_U: begin
                immExt = {instr.u.imm31_12, 12'b0};   // Low 12 bits cleared
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

//--- logic/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder (
    input  logic [1:0]           aluOp,
    input  logic [2:0]           funct3,
    input  logic                 funct7b5,
    input  logic                 opb5,      // Set for R-type, clear for OP-IMM
    output rvTypes_pkg::aluCtrlT aluCtrl
);

    import rvTypes_pkg::*;

    always_comb begin
        case (aluOp)
            2'b00: aluCtrl = ALU_ADD;      // Loads, stores, jalr
            2'b01: aluCtrl = ALU_SUB;      // Branch compare
            default: begin
                case (funct3)
                    3'b000: begin
                        // addi never subtracts even with imm[10] set
                        if (funct7b5 && opb5) begin
                            aluCtrl = ALU_SUB;
                        end else begin
                            aluCtrl = ALU_ADD;
                        end
                    end
                    3'b001:  aluCtrl = ALU_SLL;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b100:  aluCtrl = ALU_XOR;
                    3'b101:  aluCtrl = ALU_SRL;
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD;   // sltu not supported
                endcase
            end
        endcase
    end

endmodule

//--- logic/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder (
    input  rvTypes_pkg::opcodeT    op,
    output rvTypes_pkg::branchT    branch,
    output rvTypes_pkg::immSrcT    immSrc,
    output logic                   aluSrc,     // 1 selects immExt as ALU B
    output rvTypes_pkg::resultSrcT resultSrc,
    output logic                   regWrite,
    output logic                   memWrite,
    output logic [1:0]             aluOp
);

    import rvTypes_pkg::*;

    always_comb begin
        // Unknown opcodes fall through with nothing written
        aluOp     = 2'b00;
        aluSrc    = 1'b0;
        resultSrc = RES_ALU;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        immSrc    = IMM_I;
        branch    = BR_NONE;
        case (op)
            OP_R: begin
                aluOp    = 2'b10;              // Decode funct3/funct7
                regWrite = 1'b1;
            end
            OP_IMM: begin
                aluOp    = 2'b10;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                immSrc   = IMM_I;
            end
            OP_LOAD: begin
                aluSrc    = 1'b1;              // Address is rs1 + imm
                resultSrc = RES_MEM;
                regWrite  = 1'b1;
                immSrc    = IMM_I;
            end
            OP_STORE: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = IMM_S;
            end
            OP_BRANCH: begin
                aluOp  = 2'b01;                // Subtract for compare
                immSrc = IMM_B;
                branch = BR_COND;
            end
            OP_JAL: begin
                aluOp     = 2'b01;
                aluSrc    = 1'b1;
                resultSrc = RES_PC4;           // Link address
                regWrite  = 1'b1;
                immSrc    = IMM_J;
                branch    = BR_JAL;
            end
            OP_JALR: begin
                aluSrc    = 1'b1;              // Target is rs1 + imm
                resultSrc = RES_PC4;
                regWrite  = 1'b1;
                immSrc    = IMM_I;
                branch    = BR_JALR;
            end
            OP_LUI: begin
                resultSrc = RES_IMM;           // Upper immediate straight through
                regWrite  = 1'b1;
                immSrc    = IMM_U;
            end
            default: begin
                regWrite = 1'b0;
                memWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/rvTypes_pkg.sv
package rvTypes_pkg;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } aluCtrlT;

    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_COND = 2'b01,
        BR_JAL  = 2'b10,
        BR_JALR = 2'b11
    } branchT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_IMM = 2'b01,
        RES_PC4 = 2'b10,
        RES_MEM = 2'b11
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcT;

    // Field layouts of each base format, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // One instruction word, viewed per format
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrT;

endpackage

//--- logic/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Architectural word width
`define XLEN 32

// Integer register file size and index width
`define REG_COUNT 32
`define REG_ADDR_W 5

// Sequential PC increment, one 32-bit instruction
`define PC_STEP 4

`endif
